/* dsi3_pkg.sv */
// ================================================
// Shared constants and types of the DSI3 transmit block
// Two channels, 4-bit register address, 16-bit data
// Register word views assume DSI_CHANNELS is 2
// ================================================
package dsi3_pkg;

	localparam int DSI_CHANNELS = 2;
	localparam int ADDR_WIDTH   = 4;
	localparam int DATA_WIDTH   = 16;

	typedef logic [DATA_WIDTH-1:0]   data_t;
	typedef logic [ADDR_WIDTH-1:0]   addr_t;
	typedef logic [DSI_CHANNELS-1:0] dsi_logic_t;
	typedef logic [3:0]              fcount_t;      // Frame counter, wraps at 16

	// Register map
	localparam addr_t ADDR_ENABLE = 4'd0;
	localparam addr_t ADDR_CFG    = 4'd1;
	localparam addr_t ADDR_TX0    = 4'd2;
	localparam addr_t ADDR_TX1    = 4'd3;
	localparam addr_t ADDR_IRQ    = 4'd4;
	localparam addr_t ADDR_STATUS = 4'd5;

	typedef enum logic [1:0] {
		BT_4  = 2'd0,
		BT_8  = 2'd1,
		BT_16 = 2'd2,
		BT_32 = 2'd3
	} bit_time_e;

	// Clock cycles per bit, indexed by bit_time_e
	localparam logic [5:0] BIT_CLOCKS [4] = '{6'd4, 6'd8, 6'd16, 6'd32};

	localparam logic [3:0] CRC_POLY = 4'b0011;      // x^4 + x + 1, x^4 implied
	localparam logic [3:0] CRC_SEED = 4'b1010;

	typedef struct packed {
		logic [DATA_WIDTH-DSI_CHANNELS-1:0] reserved;
		dsi_logic_t                         tre;
	} enable_reg_t;

	typedef struct packed {
		logic [DATA_WIDTH-4:0] reserved;
		logic                  crc_en;
		bit_time_e             bit_time;
	} cfg_reg_t;

	typedef union packed {
		data_t       word;
		enable_reg_t enable;
		cfg_reg_t    cfg;
	} reg_word_u;

	// One serial CRC step, data bit enters at the top
	function automatic logic [3:0] crc_next(logic [3:0] crc, logic din);
		logic fb;
		fb = crc[3] ^ din;
		crc_next = {crc[2:0], 1'b0} ^ (fb ? CRC_POLY : 4'b0000);
	endfunction

endpackage

/* dsi3_ifs.sv */
// ================================================
// Register bus and channel status interfaces
// Register bus is strobe based, no handshake
// Status done and hw_error are one-cycle pulses
// ================================================
`timescale 1ns/1ns

interface reg_bus_if import dsi3_pkg::*; ();

	addr_t addr;
	data_t wdata;
	logic  wr;
	logic  rd;

	modport regs (
		input addr, wdata, wr, rd
	);

	modport chan (
		input addr, wdata, wr, rd
	);

	modport merge (
		input addr, wdata, wr, rd
	);

endinterface

interface chan_status_if ();

	logic busy;
	logic done;
	logic hw_error;
	logic active_bit;   // Current line level

	modport chan (
		output busy, done, hw_error, active_bit
	);

	modport merge (
		input busy, done, hw_error, active_bit
	);

endinterface

/* dsi3_common_regs.sv */
// ================================================
// Common ENABLE and CFG registers
// TRE bits self-clear on OT, VDSI loss or channel
// hardware error; these clears win over a write
// Read data is registered, zero when not read
// ================================================
`timescale 1ns/1ns

module dsi3_common_regs import dsi3_pkg::*; (
	input  logic           clk,
	input  logic           i_arst_n,
	reg_bus_if.regs        bus,
	input  dsi_logic_t     i_hw_error,
	input  logic           i_ot,
	input  logic           i_vdsi_en,
	input  logic           i_enable_transceivers,
	output dsi_logic_t     o_tre,
	output bit_time_e      o_bit_time,
	output logic           o_crc_en,
	output data_t          o_rdata
);

	reg_word_u  wword;
	reg_word_u  rword;
	dsi_logic_t tre_q;
	dsi_logic_t tre_next;
	bit_time_e  bit_time_q;
	logic       crc_en_q;
	logic       clear_all;
	logic       wr_enable;
	logic       wr_cfg;

	assign wword.word = bus.wdata;
	assign wr_enable  = bus.wr && (bus.addr == ADDR_ENABLE);
	assign wr_cfg     = bus.wr && (bus.addr == ADDR_CFG);

	// Supply lost while transceivers requested, or overtemperature
	assign clear_all = i_ot | (~i_vdsi_en & i_enable_transceivers);

	always_comb begin
		tre_next = tre_q;
		if (wr_enable)
			tre_next = wword.enable.tre;
		tre_next = tre_next & ~i_hw_error;  // Per channel error clear
		if (clear_all)
			tre_next = '0;
	end

	always_comb begin
		rword.word = '0;
		if (bus.rd) begin
			case (bus.addr)
				ADDR_ENABLE: rword.enable.tre = tre_q;
				ADDR_CFG: begin
					rword.cfg.bit_time = bit_time_q;
					rword.cfg.crc_en   = crc_en_q;
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			tre_q      <= '0;
			bit_time_q <= BT_4;
			crc_en_q   <= 1'b0;
			o_rdata    <= '0;
		end else begin
			tre_q   <= tre_next;
			o_rdata <= rword.word;
			if (wr_cfg) begin
				bit_time_q <= wword.cfg.bit_time;
				crc_en_q   <= wword.cfg.crc_en;
			end
		end
	end

	assign o_tre      = tre_q;
	assign o_bit_time = bit_time_q;
	assign o_crc_en   = crc_en_q;

endmodule

/* dsi3_channel.sv */
// ================================================
// One DSI3 channel transmitter
// 16 data bits MSB first, optional 4-bit CRC
// Loopback checked at mid-bit, mismatch aborts
// TX write while busy or disabled is dropped
// ================================================
`timescale 1ns/1ns

module dsi3_channel import dsi3_pkg::*; #(
	parameter addr_t TX_ADDR = ADDR_TX0
)(
	input  logic           clk,
	input  logic           i_arst_n,
	reg_bus_if.chan        bus,
	input  logic           i_enable,
	input  bit_time_e      i_bit_time,
	input  logic           i_crc_en,
	input  logic           i_rx,
	output logic           o_tx,
	chan_status_if.chan    stat
);

	logic       busy_q;
	logic       done_q;
	logic       err_q;
	logic [5:0] cyc_cnt;
	logic [4:0] bit_idx;
	data_t      shift_q;
	logic [3:0] crc_q;
	logic [5:0] bit_clocks_q;
	logic [4:0] last_idx_q;
	logic       start;
	logic       in_data;
	logic       cur_bit;
	logic       mid_bit;
	logic       end_of_bit;
	logic       mismatch;

	assign start      = bus.wr && (bus.addr == TX_ADDR) && !busy_q && i_enable;
	assign in_data    = (bit_idx < 5'd16);
	assign cur_bit    = in_data ? shift_q[DATA_WIDTH-1] : crc_q[3];
	assign mid_bit    = busy_q && (cyc_cnt == (bit_clocks_q >> 1));
	assign end_of_bit = busy_q && (cyc_cnt == (bit_clocks_q - 6'd1));
	assign mismatch   = mid_bit && (i_rx != cur_bit);

	assign o_tx = busy_q & cur_bit;     // Line idles low

	// Frame control
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			busy_q  <= 1'b0;
			done_q  <= 1'b0;
			err_q   <= 1'b0;
			cyc_cnt <= '0;
			bit_idx <= '0;
		end else begin
			done_q <= 1'b0;
			err_q  <= 1'b0;
			if (start) begin
				busy_q  <= 1'b1;
				cyc_cnt <= '0;
				bit_idx <= '0;
			end else if (busy_q) begin
				if (!i_enable) begin
					busy_q <= 1'b0;             // Enable lost, no done
				end else if (mismatch) begin
					busy_q <= 1'b0;
					err_q  <= 1'b1;
				end else if (end_of_bit) begin
					cyc_cnt <= '0;
					if (bit_idx == last_idx_q) begin
						busy_q <= 1'b0;
						done_q <= 1'b1;
					end else begin
						bit_idx <= bit_idx + 5'd1;
					end
				end else begin
					cyc_cnt <= cyc_cnt + 6'd1;
				end
			end
		end
	end

	// Command, settings and CRC
	always_ff @(posedge clk) begin
		if (start) begin
			shift_q      <= bus.wdata;
			crc_q        <= CRC_SEED;
			bit_clocks_q <= BIT_CLOCKS[i_bit_time];
			last_idx_q   <= i_crc_en ? 5'd19 : 5'd15;
		end else if (end_of_bit) begin
			if (in_data) begin
				crc_q   <= crc_next(crc_q, shift_q[DATA_WIDTH-1]);
				shift_q <= {shift_q[DATA_WIDTH-2:0], 1'b0};
			end else begin
				crc_q <= {crc_q[2:0], 1'b0};    // Shift CRC out
			end
		end
	end

	assign stat.busy       = busy_q;
	assign stat.done       = done_q;
	assign stat.hw_error   = err_q;
	assign stat.active_bit = o_tx;

endmodule

/* dsi3_status_merge.sv */
// ================================================
// Sticky IRQ flags, frame counters, status readback
// IRQ read clears the returned flags; a flag set in
// the same cycle survives. STATUS bits 3:2 give the
// current line level of each channel
// ================================================
`timescale 1ns/1ns

module dsi3_status_merge import dsi3_pkg::*; (
	input  logic           clk,
	input  logic           i_arst_n,
	reg_bus_if.merge       bus,
	chan_status_if.merge   ch0,
	chan_status_if.merge   ch1,
	input  data_t          i_rdata_common,
	output data_t          o_rdata,
	output dsi_logic_t     o_interrupt,
	output logic           o_hardware_error
);

	dsi_logic_t done_set;
	dsi_logic_t err_set;
	dsi_logic_t busy;
	dsi_logic_t line;
	dsi_logic_t done_q;
	dsi_logic_t err_q;
	fcount_t    cnt_q [DSI_CHANNELS];
	data_t      rword;
	data_t      rdata_q;
	logic       irq_read;

	assign done_set = {ch1.done, ch0.done};
	assign err_set  = {ch1.hw_error, ch0.hw_error};
	assign busy     = {ch1.busy, ch0.busy};
	assign line     = {ch1.active_bit, ch0.active_bit};
	assign irq_read = bus.rd && (bus.addr == ADDR_IRQ);

	always_comb begin
		rword = '0;
		if (bus.rd) begin
			case (bus.addr)
				ADDR_IRQ: rword[3:0] = {err_q, done_q};
				ADDR_STATUS: begin
					rword[1:0]  = busy;
					rword[3:2]  = line;
					rword[7:4]  = cnt_q[0];
					rword[11:8] = cnt_q[1];
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			done_q  <= '0;
			err_q   <= '0;
			rdata_q <= '0;
			for (int i = 0; i < DSI_CHANNELS; i++)
				cnt_q[i] <= '0;
		end else begin
			done_q  <= (irq_read ? '0 : done_q) | done_set;
			err_q   <= (irq_read ? '0 : err_q) | err_set;
			rdata_q <= rword;
			for (int i = 0; i < DSI_CHANNELS; i++) begin
				if (done_set[i])
					cnt_q[i] <= cnt_q[i] + 4'd1;
			end
		end
	end

	assign o_rdata          = rdata_q | i_rdata_common;    // Block read data OR
	assign o_interrupt      = done_q | err_q;
	assign o_hardware_error = |err_q;

endmodule

/* dsi3_top.sv */
// ================================================
// Two-channel DSI3 master transmit subsystem
// Channel i enabled by TRE[i] and transceiver enable
// i_rx is the loopback of each channel's o_tx
// ================================================
`timescale 1ns/1ns

module dsi3_top import dsi3_pkg::*; (
	input  logic       clk,
	input  logic       i_arst_n,
	input  addr_t      i_addr,
	input  data_t      i_wdata,
	input  logic       i_wr,
	input  logic       i_rd,
	input  logic       i_ot,
	input  logic       i_vdsi_en,
	input  logic       i_enable_transceivers,
	input  dsi_logic_t i_rx,
	output dsi_logic_t o_tx,
	output dsi_logic_t o_busy,
	output data_t      o_rdata,
	output dsi_logic_t o_interrupt,
	output logic       o_hardware_error
);

	reg_bus_if     bus ();
	chan_status_if stat [DSI_CHANNELS] ();

	dsi_logic_t tre;
	dsi_logic_t hw_error;
	bit_time_e  bit_time;
	logic       crc_en;
	data_t      rdata_common;

	assign bus.addr  = i_addr;
	assign bus.wdata = i_wdata;
	assign bus.wr    = i_wr;
	assign bus.rd    = i_rd;

	dsi3_common_regs i_common_regs (
		.clk                   (clk),
		.i_arst_n              (i_arst_n),
		.bus                   (bus.regs),
		.i_hw_error            (hw_error),
		.i_ot                  (i_ot),
		.i_vdsi_en             (i_vdsi_en),
		.i_enable_transceivers (i_enable_transceivers),
		.o_tre                 (tre),
		.o_bit_time            (bit_time),
		.o_crc_en              (crc_en),
		.o_rdata               (rdata_common)
	);

	generate
		for (genvar i = 0; i < DSI_CHANNELS; i++) begin : gen_channels
			dsi3_channel #(
				.TX_ADDR (i == 0 ? ADDR_TX0 : ADDR_TX1)
			) i_channel (
				.clk        (clk),
				.i_arst_n   (i_arst_n),
				.bus        (bus.chan),
				.i_enable   (tre[i] & i_enable_transceivers),
				.i_bit_time (bit_time),
				.i_crc_en   (crc_en),
				.i_rx       (i_rx[i]),
				.o_tx       (o_tx[i]),
				.stat       (stat[i].chan)
			);

			assign hw_error[i] = stat[i].hw_error;
			assign o_busy[i]   = stat[i].busy;
		end
	endgenerate

	dsi3_status_merge i_status_merge (
		.clk              (clk),
		.i_arst_n         (i_arst_n),
		.bus              (bus.merge),
		.ch0              (stat[0].merge),
		.ch1              (stat[1].merge),
		.i_rdata_common   (rdata_common),
		.o_rdata          (o_rdata),
		.o_interrupt      (o_interrupt),
		.o_hardware_error (o_hardware_error)
	);

endmodule

/* tb_clkgen.sv */
// ================================================
// Free running testbench clock, starts low
// Period in ns, even values only
// ================================================
`timescale 1ns/1ns

module tb_clkgen #(
	parameter int PERIOD = 40
)(
	output logic o_clk
);

	initial o_clk = 1'b0;

	always #(PERIOD / 2) o_clk = ~o_clk;

endmodule

/* dsi3_tb.sv */
// ================================================
// Testbench for the two-channel DSI3 transmitter
// Inputs change 2 ns after the rising edge
// Loopback copies o_tx to i_rx unless rx_flip is set
// Frame bits sampled at falling edges, mid-bit only
// ================================================
`timescale 1ns/1ns

module dsi3_tb import dsi3_pkg::*; ();

	localparam int CYCLE_LIMIT = 40 * (20 * 32 + 20);   // 40 longest frames

	logic       clk;
	logic       i_arst_n;
	addr_t      i_addr;
	data_t      i_wdata;
	logic       i_wr;
	logic       i_rd;
	logic       i_ot;
	logic       i_vdsi_en;
	logic       i_enable_transceivers;
	dsi_logic_t i_rx;
	dsi_logic_t rx_flip;
	dsi_logic_t o_tx;
	dsi_logic_t o_busy;
	data_t      o_rdata;
	dsi_logic_t o_interrupt;
	logic       o_hardware_error;

	logic [31:0] lcg_state;
	int          test_count;
	int          err_count;
	int          cycles;

	// Reference model state
	dsi_logic_t  tre_m;
	dsi_logic_t  done_m;
	dsi_logic_t  err_m;
	fcount_t     cnt_m [2];
	logic [1:0]  bt_m;
	logic        crc_m;

	tb_clkgen #(.PERIOD(40)) u_clkgen (.o_clk(clk));

	dsi3_top u_dut (
		.clk                   (clk),
		.i_arst_n              (i_arst_n),
		.i_addr                (i_addr),
		.i_wdata               (i_wdata),
		.i_wr                  (i_wr),
		.i_rd                  (i_rd),
		.i_ot                  (i_ot),
		.i_vdsi_en             (i_vdsi_en),
		.i_enable_transceivers (i_enable_transceivers),
		.i_rx                  (i_rx),
		.o_tx                  (o_tx),
		.o_busy                (o_busy),
		.o_rdata               (o_rdata),
		.o_interrupt           (o_interrupt),
		.o_hardware_error      (o_hardware_error)
	);

	assign i_rx = o_tx ^ rx_flip;

	function automatic logic [15:0] lcg_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[31:16];
	endfunction

	// Remainder of seed*x^16 + data*x^4 over x^4+x+1
	function automatic logic [3:0] model_crc(data_t d);
		logic [19:0] v;
		v = {d, 4'h0} ^ {4'b1010, 16'h0000};
		for (int i = 19; i >= 4; i--) begin
			if (v[i])
				v = v ^ (20'b10011 << (i - 4));
		end
		return v[3:0];
	endfunction

	function automatic data_t status_exp();
		return {4'h0, cnt_m[1], cnt_m[0], 4'h0};   // Idle: busy and line low
	endfunction

	task automatic check_word(input string name, input data_t exp, input data_t act);
		test_count++;
		if (exp !== act) begin
			err_count++;
			$display("ERR %s expected %h actual %h", name, exp, act);
		end else
			$display("ok  %s %h", name, act);
	endtask

	task automatic check_bits(input string name, input dsi_logic_t exp, input dsi_logic_t act);
		test_count++;
		if (exp !== act) begin
			err_count++;
			$display("ERR %s expected %b actual %b", name, exp, act);
		end else
			$display("ok  %s %b", name, act);
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		test_count++;
		if (exp !== act) begin
			err_count++;
			$display("ERR %s expected %b actual %b", name, exp, act);
		end else
			$display("ok  %s %b", name, act);
	endtask

	task automatic tick();
		@(posedge clk);
		#2;
	endtask

	task automatic write_reg(input addr_t a, input data_t d);
		i_addr  = a;
		i_wdata = d;
		i_wr    = 1'b1;
		tick();
		i_wr = 1'b0;
	endtask

	task automatic read_reg(input addr_t a, output data_t v);
		i_addr = a;
		i_rd   = 1'b1;
		tick();
		i_rd = 1'b0;
		@(negedge clk);
		v = o_rdata;
		tick();
	endtask

	task automatic expect_reg(input string name, input addr_t a, input data_t exp);
		data_t v;
		read_reg(a, v);
		check_word(name, exp, v);
	endtask

	// Follows one frame from busy rise to busy fall
	task automatic watch_frame(input int ch, input data_t cmd, input int nbits,
			input int bclk, input string tag);
		logic [19:0] got;
		int          cyc;
		int          wc;
		got = '0;
		cyc = 0;
		wc  = 0;
		@(negedge clk);
		while (!o_busy[ch] && wc < 8) begin
			@(negedge clk);
			wc++;
		end
		if (!o_busy[ch]) begin
			err_count++;
			$display("%s: channel %0d never went busy", tag, ch);
		end
		while (o_busy[ch] && cyc < 700) begin
			if (cyc % bclk == bclk / 2)
				got = {got[18:0], o_tx[ch]};
			cyc++;
			@(negedge clk);
		end
		check_word({tag, "_len"}, data_t'(nbits * bclk), data_t'(cyc));
		if (nbits == 20) begin
			check_word({tag, "_data"}, cmd, got[19:4]);
			check_word({tag, "_crc"}, {12'h0, model_crc(cmd)}, {12'h0, got[3:0]});
		end else
			check_word({tag, "_data"}, cmd, got[15:0]);
	endtask

	task automatic run_frame_pair(input int n);
		data_t w;
		data_t c0;
		data_t c1;
		int    bclk;
		int    nbits;
		w     = lcg_rand();
		bt_m  = w[1:0];
		crc_m = w[8];
		write_reg(ADDR_CFG, {13'h0, crc_m, bt_m});
		bclk  = 4 << bt_m;
		nbits = crc_m ? 20 : 16;
		c0    = lcg_rand();
		c1    = lcg_rand();
		fork
			watch_frame(0, c0, nbits, bclk, $sformatf("f%0d_ch0", n));
			watch_frame(1, c1, nbits, bclk, $sformatf("f%0d_ch1", n));
			begin
				write_reg(ADDR_TX0, c0);
				write_reg(ADDR_TX1, c1);
			end
		join
		tick();
		done_m = 2'b11;
		cnt_m[0]++;
		cnt_m[1]++;
	endtask

	task automatic inject_error();
		data_t w;
		int    ch;
		int    bclk;
		int    k;
		int    wc;
		w     = lcg_rand();
		ch    = w[0];
		bt_m  = w[2:1];
		crc_m = w[3];
		write_reg(ADDR_ENABLE, 16'h0003);
		tre_m = 2'b11;
		write_reg(ADDR_CFG, {13'h0, crc_m, bt_m});
		bclk = 4 << bt_m;
		k    = int'(lcg_rand()) % (15 * bclk);    // Leaves at least one mid-bit
		write_reg(addr_t'(ADDR_TX0 + ch), lcg_rand());
		repeat (k) tick();
		rx_flip[ch] = 1'b1;
		wc = 0;
		while (o_busy[ch] && wc < 700) begin
			tick();
			wc++;
		end
		if (o_busy[ch]) begin
			err_count++;
			$display("channel %0d kept running with a broken loopback", ch);
		end
		rx_flip = '0;
		tick();
		tick();
		err_m[ch] = 1'b1;
		tre_m[ch] = 1'b0;
		check_bit("err_hw_error", 1'b1, o_hardware_error);
		check_bits("err_irq_line", done_m | err_m, o_interrupt);
		expect_reg("err_irq", ADDR_IRQ, {12'h0, err_m, done_m});
		err_m = '0;
		expect_reg("err_enable", ADDR_ENABLE, {14'h0, tre_m});
		check_bit("err_hw_cleared", 1'b0, o_hardware_error);
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Done: errors found");
			$finish;
		end
	end

	initial begin
		data_t w;
		data_t c;
		int    bclk;
		int    nbits;
		lcg_state  = 32'd39490;
		test_count = 0;
		err_count  = 0;
		cycles     = 0;
		tre_m      = '0;
		done_m     = '0;
		err_m      = '0;
		cnt_m[0]   = '0;
		cnt_m[1]   = '0;
		bt_m       = 2'd0;
		crc_m      = 1'b0;
		i_arst_n   = 1'b0;
		i_addr     = '0;
		i_wdata    = '0;
		i_wr       = 1'b0;
		i_rd       = 1'b0;
		i_ot       = 1'b0;
		i_vdsi_en  = 1'b1;
		i_enable_transceivers = 1'b1;
		rx_flip    = '0;
		repeat (8) @(posedge clk);
		#2;
		i_arst_n = 1'b1;

		check_bits("reset_busy", 2'b00, o_busy);
		check_bits("reset_irq_line", 2'b00, o_interrupt);
		check_bit("reset_hw_error", 1'b0, o_hardware_error);
		expect_reg("reset_enable", ADDR_ENABLE, 16'h0000);
		expect_reg("reset_cfg", ADDR_CFG, 16'h0000);
		expect_reg("reset_status", ADDR_STATUS, 16'h0000);

		// Register readback
		for (int i = 0; i < 6; i++) begin
			w = lcg_rand();
			write_reg(ADDR_ENABLE, w);
			tre_m = w[1:0];
			expect_reg($sformatf("enable_rd%0d", i), ADDR_ENABLE, {14'h0, tre_m});
			w = lcg_rand();
			write_reg(ADDR_CFG, w);
			bt_m  = w[1:0];
			crc_m = w[2];
			expect_reg($sformatf("cfg_rd%0d", i), ADDR_CFG, {13'h0, crc_m, bt_m});
		end

		// Both channels in parallel, then flags and counters
		write_reg(ADDR_ENABLE, 16'h0003);
		tre_m = 2'b11;
		for (int i = 0; i < 6; i++)
			run_frame_pair(i);
		check_bits("irq_line", done_m | err_m, o_interrupt);
		expect_reg("irq_first", ADDR_IRQ, {12'h0, err_m, done_m});
		done_m = '0;
		expect_reg("irq_second", ADDR_IRQ, 16'h0000);
		expect_reg("status_counts", ADDR_STATUS, status_exp());

		inject_error();

		// OT clear beats a same-cycle ENABLE write
		i_ot = 1'b1;
		write_reg(ADDR_ENABLE, 16'h0003);
		i_ot  = 1'b0;
		tre_m = 2'b00;
		expect_reg("ot_enable", ADDR_ENABLE, 16'h0000);
		write_reg(ADDR_TX0, lcg_rand());
		tick();
		tick();
		check_bits("disabled_busy", 2'b00, o_busy);
		expect_reg("disabled_status", ADDR_STATUS, status_exp());

		write_reg(ADDR_ENABLE, 16'h0003);
		tre_m = 2'b11;
		expect_reg("vdsi_before", ADDR_ENABLE, {14'h0, tre_m});
		write_reg(ADDR_TX0, lcg_rand());    // Frame cut short by enable loss
		i_vdsi_en = 1'b0;
		tick();
		i_vdsi_en = 1'b1;
		tre_m     = 2'b00;
		expect_reg("vdsi_enable", ADDR_ENABLE, 16'h0000);
		check_bits("vdsi_abort_busy", 2'b00, o_busy);
		expect_reg("vdsi_abort_irq", ADDR_IRQ, {12'h0, err_m, done_m});
		expect_reg("vdsi_abort_status", ADDR_STATUS, status_exp());

		// Second command to a busy channel is dropped
		write_reg(ADDR_ENABLE, 16'h0003);
		tre_m = 2'b11;
		bclk  = 4 << bt_m;
		nbits = crc_m ? 20 : 16;
		c     = lcg_rand();
		fork
			watch_frame(0, c, nbits, bclk, "busy_write");
			begin
				write_reg(ADDR_TX0, c);
				// Channel 0 busy, its line at the first bit
				expect_reg("busy_write_run", ADDR_STATUS,
					{4'h0, cnt_m[1], cnt_m[0], 1'b0, c[15], 2'b01});
				tick();
				write_reg(ADDR_TX0, ~c);
			end
		join
		tick();
		cnt_m[0]++;
		done_m[0] = 1'b1;
		expect_reg("busy_write_status", ADDR_STATUS, status_exp());
		expect_reg("busy_write_irq", ADDR_IRQ, {12'h0, err_m, done_m});
		done_m = '0;

		$display("tests %0d errors %0d", test_count, err_count);
		if (err_count == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

/* flist.f */
dsi3_pkg.sv
dsi3_ifs.sv
dsi3_common_regs.sv
dsi3_channel.sv
dsi3_status_merge.sv
dsi3_top.sv
tb_clkgen.sv
dsi3_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module dsi3_tb -f flist.f -o sim_dsi3
out=$(./obj_dir/sim_dsi3)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Done: no errors"; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
